/* design/conv_engine_settings.svh */
`ifndef CONV_ENGINE_SETTINGS_SVH
`define CONV_ENGINE_SETTINGS_SVH

// datapath widths
`define CE_ACT_W 12
`define CE_PARAM_W 8
`define CE_PROD_W 20
`define CE_ACC_W 27

// input image and activation bank geometry
`define CE_IMG_DIM 28
`define CE_NUM_BANKS 4
`define CE_WORDS_PER_ADDR 16
`define CE_BANK_ADDR_W 6
`define CE_ADDR_ROW_STRIDE 6

// convolution
`define CE_NUM_TAPS 9
`define CE_NUM_CH 4

// output quantization
`define CE_OUT_MAX 2047
`define CE_ROUND 64
`define CE_BIAS_SHIFT 8
`define CE_OUT_LSB 7

`endif

/* design/conv_engine_pkg.sv */
`default_nettype none
`include "conv_engine_settings.svh"

package conv_engine_pkg;

    typedef logic signed [`CE_ACT_W-1:0] act_t;
    typedef logic signed [`CE_PARAM_W-1:0] param_t;
    typedef logic signed [`CE_PROD_W-1:0] prod_t;

    // wen and wordmask are active low like the SRAM pins
    typedef struct packed {
        logic [`CE_NUM_BANKS-1:0]      wen;
        logic [`CE_WORDS_PER_ADDR-1:0] wordmask;
        logic [`CE_BANK_ADDR_W-1:0]    waddr;
        act_t [`CE_WORDS_PER_ADDR-1:0] wdata;
    } bank_write_t;

    // pix[k] is row k/4 and column k%4 of the 4x4 window
    typedef struct packed {
        logic        valid;
        logic        first;
        logic        last;
        act_t [15:0] pix;
    } patch_t;

    typedef struct packed {
        param_t [`CE_NUM_TAPS-1:0] weight;
        param_t                    bias;
    } kernel_t;

    // index 0..8 selects a weight, 9 the bias
    typedef struct packed {
        logic       valid;
        logic [3:0] index;
        param_t     value;
    } coeff_write_t;

    // prod[o*9 + t] is tap t of output o
    typedef struct packed {
        logic                         valid;
        logic                         first;
        logic                         last;
        prod_t [4*`CE_NUM_TAPS-1:0]   prod;
    } products_t;

    // out[0] top-left, out[1] top-right, out[2] bottom-left, out[3] bottom-right
    typedef struct packed {
        logic                     valid;
        logic [3:0][`CE_ACT_W-1:0] out;
    } conv_result_t;

endpackage

`default_nettype wire

/* design/image_loader.sv */
`default_nettype none
`include "conv_engine_settings.svh"

module image_loader (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    enable,
    input  wire conv_engine_pkg::act_t   input_data,
    output logic                         busy,
    output logic                         done,
    output conv_engine_pkg::bank_write_t bank_wr
);

    localparam int CNT_W = $clog2(`CE_IMG_DIM);
    localparam int ADDR_W = `CE_BANK_ADDR_W;
    localparam int WORDS = `CE_WORDS_PER_ADDR;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_FINISHED
    } state_t;

    state_t                     state;
    logic [CNT_W-1:0]           x;
    logic [CNT_W-1:0]           y;
    logic                       sample;
    logic                       last_col;
    logic                       last_pix;
    logic [`CE_NUM_BANKS-1:0]   wen_q;
    logic [WORDS-1:0]           wordmask_q;
    logic [ADDR_W-1:0]          waddr_q;
    conv_engine_pkg::act_t      pix_q;

    // the start edge already takes pixel (0,0)
    assign sample = (state == ST_LOAD) || (state == ST_IDLE && enable);
    assign last_col = (x == CNT_W'(`CE_IMG_DIM - 1));
    assign last_pix = last_col && (y == CNT_W'(`CE_IMG_DIM - 1));
    assign busy = (state == ST_LOAD);
    assign done = (state == ST_FINISHED);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            x <= '0;
            y <= '0;
        end else begin
            case (state)
                ST_IDLE:     if (enable) state <= ST_LOAD;
                ST_LOAD:     if (last_pix) state <= ST_FINISHED;
                ST_FINISHED: if (enable) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
            // raster scan, x across the row then y down
            if (sample) begin
                x <= last_col ? '0 : x + 1'b1;
                if (last_pix)
                    y <= '0;
                else if (last_col)
                    y <= y + 1'b1;
            end
        end
    end

    // bank from bit 2 of each coordinate, word from the low two bits
    always_ff @(posedge clk) begin
        if (!rst_n)
            wen_q <= '1;
        else
            wen_q <= sample ? ~(`CE_NUM_BANKS'(1) << {y[2], x[2]}) : '1;
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            wordmask_q <= ~(WORDS'(1) << (4'd15 - {y[0], x[0], y[1], x[1]}));
            waddr_q <= ADDR_W'(x[4:3]) + ADDR_W'(`CE_ADDR_ROW_STRIDE * y[4:3]);
            pix_q <= input_data;
        end
    end

    always_comb begin
        bank_wr.wen = wen_q;
        bank_wr.wordmask = wordmask_q;
        bank_wr.waddr = waddr_q;
        for (int k = 0; k < WORDS; k++) begin
            bank_wr.wdata[k] = pix_q;
        end
    end

    a_one_bank: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(~bank_wr.wen))
        else $error("more than one bank written at once");

    a_one_word: assert property (@(posedge clk) disable iff (!rst_n)
        !(&bank_wr.wen) |-> $onehot(~bank_wr.wordmask))
        else $error("bank write without exactly one word enabled");

endmodule

`default_nettype wire

/* design/coeff_regs.sv */
`default_nettype none
`include "conv_engine_settings.svh"

module coeff_regs (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire conv_engine_pkg::coeff_write_t coeff_wr,
    output conv_engine_pkg::kernel_t           kernel
);

    localparam logic [3:0] BIAS_INDEX = 4'(`CE_NUM_TAPS);

    logic is_weight;
    logic is_bias;

    assign is_weight = coeff_wr.valid && (coeff_wr.index < BIAS_INDEX);
    assign is_bias = coeff_wr.valid && (coeff_wr.index == BIAS_INDEX);

    // weights in raster order of the 3x3 kernel, bias after them
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            kernel <= '0;
        end else begin
            if (is_weight)
                kernel.weight[coeff_wr.index] <= coeff_wr.value;
            if (is_bias)
                kernel.bias <= coeff_wr.value;
        end
    end

    a_index_range: assert property (@(posedge clk) disable iff (!rst_n)
        coeff_wr.valid |-> coeff_wr.index <= BIAS_INDEX)
        else $error("coefficient write with index %0d out of range", coeff_wr.index);

endmodule

`default_nettype wire

/* design/conv_mac_array.sv */
`default_nettype none
`include "conv_engine_settings.svh"

module conv_mac_array (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire conv_engine_pkg::patch_t  patch_in,
    input  wire conv_engine_pkg::kernel_t kernel,
    output conv_engine_pkg::products_t    products
);

    localparam int TAPS = `CE_NUM_TAPS;

    conv_engine_pkg::patch_t    patch_q;
    conv_engine_pkg::products_t prod_d;

    // stage 1 holds the patch so the multipliers see a stable window
    always_ff @(posedge clk) begin
        patch_q <= patch_in;
        if (!rst_n)
            patch_q.valid <= 1'b0;
    end

    // output o sits at row o/2, column o%2 of the patch
    // tap t reads kernel row t/3, column t%3
    always_comb begin
        prod_d.valid = patch_q.valid;
        prod_d.first = patch_q.first;
        prod_d.last = patch_q.last;
        for (int o = 0; o < 4; o++) begin
            for (int t = 0; t < TAPS; t++) begin
                // signed operands widen to the product width before multiplying
                prod_d.prod[o * TAPS + t] = kernel.weight[t] *
                    patch_q.pix[((o / 2) + (t / 3)) * 4 + (o % 2) + (t % 3)];
            end
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        products <= prod_d;
        if (!rst_n)
            products.valid <= 1'b0;
    end

endmodule

`default_nettype wire

/* design/conv_accumulator.sv */
`default_nettype none
`include "conv_engine_settings.svh"

module conv_accumulator (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire conv_engine_pkg::products_t products,
    input  wire conv_engine_pkg::kernel_t   kernel,
    output conv_engine_pkg::conv_result_t   result
);

    localparam int ACC_W = `CE_ACC_W;
    localparam int ACT_W = `CE_ACT_W;
    localparam int TAPS = `CE_NUM_TAPS;
    // top kept bit, anything set from here upward saturates
    localparam int OUT_MSB = `CE_OUT_LSB + ACT_W - 1;

    typedef logic signed [ACC_W-1:0] acc_t;

    acc_t                          acc_q [4];
    acc_t                          acc_d [4];
    acc_t                          bias_term;
    conv_engine_pkg::conv_result_t result_d;
    logic                          group_open;

    always_comb begin
        acc_t term;
        bias_term = (acc_t'(kernel.bias) <<< `CE_BIAS_SHIFT) + acc_t'(`CE_ROUND);
        result_d.valid = products.valid && products.last;
        for (int o = 0; o < 4; o++) begin
            term = '0;
            for (int t = 0; t < TAPS; t++) begin
                term = term + acc_t'(products.prod[o * TAPS + t]);
            end
            // first channel of a group starts from bias plus rounding
            acc_d[o] = products.first ? term + bias_term : acc_q[o] + term;
            // relu, then clamp, then keep the middle bits
            if (acc_d[o][ACC_W-1])
                result_d.out[o] = '0;
            else if (|acc_d[o][ACC_W-2:OUT_MSB])
                result_d.out[o] = ACT_W'(`CE_OUT_MAX);
            else
                result_d.out[o] = acc_d[o][OUT_MSB:`CE_OUT_LSB];
        end
    end

    always_ff @(posedge clk) begin
        if (products.valid) begin
            for (int o = 0; o < 4; o++) begin
                acc_q[o] <= acc_d[o];
            end
        end
    end

    // stage 3
    always_ff @(posedge clk) begin
        if (!rst_n)
            result.valid <= 1'b0;
        else
            result.valid <= result_d.valid;
        if (result_d.valid)
            result.out <= result_d.out;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            group_open <= 1'b0;
        else if (products.valid)
            group_open <= !products.last;
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        products.valid && products.first |-> !group_open)
        else $error("new group started before the previous group saw its last channel");

endmodule

`default_nettype wire

/* design/conv_engine_top.sv */
`default_nettype none

module conv_engine_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         enable,
    input  wire conv_engine_pkg::act_t        input_data,
    output logic                              busy,
    output logic                              done,
    output conv_engine_pkg::bank_write_t      bank_wr,
    input  wire conv_engine_pkg::coeff_write_t coeff_wr,
    input  wire conv_engine_pkg::patch_t      patch_in,
    output conv_engine_pkg::conv_result_t     result
);

    conv_engine_pkg::kernel_t   kernel;
    conv_engine_pkg::products_t products;

    // image path into the activation banks
    image_loader u_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .input_data (input_data),
        .busy       (busy),
        .done       (done),
        .bank_wr    (bank_wr)
    );

    coeff_regs u_coeff (
        .clk      (clk),
        .rst_n    (rst_n),
        .coeff_wr (coeff_wr),
        .kernel   (kernel)
    );

    // three stage convolution pipeline
    conv_mac_array u_mac (
        .clk      (clk),
        .rst_n    (rst_n),
        .patch_in (patch_in),
        .kernel   (kernel),
        .products (products)
    );

    conv_accumulator u_acc (
        .clk      (clk),
        .rst_n    (rst_n),
        .products (products),
        .kernel   (kernel),
        .result   (result)
    );

endmodule

`default_nettype wire

/* test/tb_conv_engine.sv */
`default_nettype none
`include "conv_engine_settings.svh"

module tb_conv_engine;

    timeunit 1ns;
    timeprecision 1ps;

    // load of 784 pixels plus the convolution tests stay under 1000 cycles
    localparam int MAX_CYCLES = 2000;
    localparam int NUM_PIX = `CE_IMG_DIM * `CE_IMG_DIM;
    localparam int OUT_MSB = `CE_OUT_LSB + `CE_ACT_W - 1;

    typedef logic [3:0][`CE_ACT_W-1:0] outs_t;

    logic                          clk;
    logic                          rst_n;
    logic                          enable;
    conv_engine_pkg::act_t         input_data;
    logic                          busy;
    logic                          done;
    conv_engine_pkg::bank_write_t  bank_wr;
    conv_engine_pkg::coeff_write_t coeff_wr;
    conv_engine_pkg::patch_t       patch_in;
    conv_engine_pkg::conv_result_t result;

    integer                       seed = 9;
    string                        test_name = "reset";
    int                           value_errs = 0;
    int                           other_errs = 0;
    int                           cycles = 0;
    int                           wr_count = 0;
    int                           w_model [`CE_NUM_TAPS];
    int                           b_model = 0;
    conv_engine_pkg::bank_write_t wr_q [$];
    outs_t                        res_q [$];
    conv_engine_pkg::bank_write_t wr_head;
    outs_t                        res_head;
    int                           wr_left = 0;
    int                           res_left = 0;
    // last flag of the sampled patch, delayed through the three stages
    logic [2:0]                   last_pipe = '0;

    conv_engine_top UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .input_data (input_data),
        .busy       (busy),
        .done       (done),
        .bank_wr    (bank_wr),
        .coeff_wr   (coeff_wr),
        .patch_in   (patch_in),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // pixel (x, y) goes to bank {y2, x2}, word {y0, x0, y1, x1} from the top
    function automatic conv_engine_pkg::bank_write_t predict_write(input int x, input int y,
                                                                    input conv_engine_pkg::act_t pix);
        conv_engine_pkg::bank_write_t w;
        int bank;
        int word;
        bank = ((y >> 2) & 1) * 2 + ((x >> 2) & 1);
        word = 4 * (((y & 1) * 2) + (x & 1)) + (((y >> 1) & 1) * 2 + ((x >> 1) & 1));
        w.wen = ~(4'(1) << bank);
        w.wordmask = ~(16'(1) << (15 - word));
        w.waddr = 6'(((x >> 3) & 3) + 6 * ((y >> 3) & 3));
        for (int k = 0; k < `CE_WORDS_PER_ADDR; k++)
            w.wdata[k] = pix;
        return w;
    endfunction

    function automatic longint window_sum(input conv_engine_pkg::patch_t p, input int r,
                                          input int c);
        longint s;
        s = 0;
        for (int i = 0; i < 3; i++)
            for (int j = 0; j < 3; j++)
                s += longint'(w_model[i * 3 + j]) * longint'(p.pix[(r + i) * 4 + c + j]);
        return s;
    endfunction

    function automatic logic [`CE_ACT_W-1:0] quantize(input longint acc);
        if (acc < 0)
            return '0;
        if ((acc >>> OUT_MSB) != 0)
            return `CE_ACT_W'(`CE_OUT_MAX);
        return `CE_ACT_W'(acc >>> `CE_OUT_LSB);
    endfunction

    task automatic refresh_heads();
        wr_left = wr_q.size();
        res_left = res_q.size();
        wr_head = (wr_left > 0) ? wr_q[0] : '0;
        res_head = (res_left > 0) ? res_q[0] : '0;
    endtask

    // retire the expected entries that the DUT presented on this edge
    always @(posedge clk) begin
        if (rst_n && bank_wr.wen != '1) begin
            wr_count++;
            if (wr_q.size() > 0)
                void'(wr_q.pop_front());
        end
        if (rst_n && result.valid && res_q.size() > 0)
            void'(res_q.pop_front());
        refresh_heads();
        last_pipe <= rst_n ? {last_pipe[1:0], patch_in.valid && patch_in.last} : 3'b000;
    end

    a_wr_expected: assert property (@(posedge clk) disable iff (!rst_n)
        bank_wr.wen != '1 |-> wr_left > 0)
        else begin
            other_errs++;
            $display("%s: bank write seen when none was expected", test_name);
        end

    a_wr_value: assert property (@(posedge clk) disable iff (!rst_n)
        bank_wr.wen != '1 && wr_left > 0 |-> bank_wr == wr_head)
        else begin
            value_errs++;
            $display("ERR %s bank_wr expected %h actual %h", test_name,
                     $sampled(wr_head), $sampled(bank_wr));
        end

    // busy through the load, done together with the last write
    a_load_flags: assert property (@(posedge clk) disable iff (!rst_n)
        bank_wr.wen != '1 && wr_left > 0 |-> busy == (wr_left > 1) && done == (wr_left == 1))
        else begin
            other_errs++;
            $display("%s: busy or done wrong with %0d writes left", test_name, $sampled(wr_left));
        end

    a_res_expected: assert property (@(posedge clk) disable iff (!rst_n)
        result.valid |-> res_left > 0)
        else begin
            other_errs++;
            $display("%s: result seen when none was expected", test_name);
        end

    a_res_value: assert property (@(posedge clk) disable iff (!rst_n)
        result.valid && res_left > 0 |-> result.out == res_head)
        else begin
            value_errs++;
            $display("ERR %s result expected %h actual %h", test_name,
                     $sampled(res_head), $sampled(result.out));
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        result.valid == last_pipe[2])
        else begin
            other_errs++;
            $display("%s: result valid not three edges after the last patch", test_name);
        end

    task automatic load_image();
        conv_engine_pkg::act_t img [NUM_PIX];
        test_name = "full_load";
        for (int y = 0; y < `CE_IMG_DIM; y++) begin
            for (int x = 0; x < `CE_IMG_DIM; x++) begin
                img[y * `CE_IMG_DIM + x] = conv_engine_pkg::act_t'($random(seed));
                wr_q.push_back(predict_write(x, y, img[y * `CE_IMG_DIM + x]));
            end
        end
        refresh_heads();
        for (int k = 0; k < NUM_PIX; k++) begin
            @(posedge clk);
            #1;
            enable = (k == 0);
            input_data = img[k];
        end
        while (!done) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        assert (wr_count == NUM_PIX && !busy) else begin
            other_errs++;
            $display("loader made %0d writes instead of %0d", wr_count, NUM_PIX);
        end
    endtask

    // kind 0 random, 1 all maximum, 2 all minimum
    task automatic load_kernel(input int kind);
        conv_engine_pkg::param_t v;
        for (int i = 0; i <= `CE_NUM_TAPS; i++) begin
            case (kind)
                0: v = conv_engine_pkg::param_t'($random(seed));
                1: v = conv_engine_pkg::param_t'(127);
                default: v = conv_engine_pkg::param_t'(-128);
            endcase
            @(posedge clk);
            #1;
            coeff_wr.valid = 1'b1;
            coeff_wr.index = 4'(i);
            coeff_wr.value = v;
            if (i < `CE_NUM_TAPS)
                w_model[i] = int'(v);
            else
                b_model = int'(v);
        end
        @(posedge clk);
        #1;
        coeff_wr.valid = 1'b0;
    endtask

    task automatic send_group(input int nch, input bit max_pix);
        conv_engine_pkg::patch_t p;
        longint acc [4];
        outs_t exp_out;
        for (int o = 0; o < 4; o++)
            acc[o] = longint'(b_model) * 256 + 64;
        for (int ch = 0; ch < nch; ch++) begin
            p.valid = 1'b1;
            p.first = (ch == 0);
            p.last = (ch == nch - 1);
            for (int k = 0; k < 16; k++)
                p.pix[k] = max_pix ? conv_engine_pkg::act_t'(2047)
                                   : conv_engine_pkg::act_t'($random(seed) % 512);
            for (int o = 0; o < 4; o++)
                acc[o] += window_sum(p, o / 2, o % 2);
            @(posedge clk);
            #1;
            patch_in = p;
        end
        for (int o = 0; o < 4; o++)
            exp_out[o] = quantize(acc[o]);
        res_q.push_back(exp_out);
        refresh_heads();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
            patch_in.valid = 1'b0;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        enable = 1'b0;
        input_data = '0;
        coeff_wr = '0;
        patch_in = '0;
        for (int t = 0; t < `CE_NUM_TAPS; t++)
            w_model[t] = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        assert (!busy && !done && bank_wr.wen == '1 && !result.valid) else begin
            other_errs++;
            $display("outputs not in their reset state after reset");
        end

        load_image();

        test_name = "single_channel";
        load_kernel(0);
        repeat (8) send_group(1, 1'b0);
        idle_cycles(4);

        // groups back to back so two of them share the pipeline
        test_name = "multi_channel";
        load_kernel(0);
        repeat (6) send_group(`CE_NUM_CH, 1'b0);
        idle_cycles(4);

        test_name = "clamp_high";
        load_kernel(1);
        repeat (2) send_group(`CE_NUM_CH, 1'b1);
        idle_cycles(4);

        test_name = "clamp_low";
        load_kernel(2);
        repeat (2) send_group(`CE_NUM_CH, 1'b1);
        idle_cycles(4);

        assert (wr_left == 0 && res_left == 0) else begin
            other_errs++;
            $display("outputs never appeared, %0d writes and %0d results left",
                     wr_left, res_left);
        end

        $display("errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
        if (value_errs + other_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* conv_engine_top.f */
+incdir+design
design/conv_engine_pkg.sv
design/image_loader.sv
design/coeff_regs.sv
design/conv_mac_array.sv
design/conv_accumulator.sv
design/conv_engine_top.sv
test/tb_conv_engine.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_conv_engine
FILELIST  ?= conv_engine_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard design/*.sv design/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	$(SIM_BIN) > $(LOG) 2>&1 || echo "TESTBENCH FAILED" >> $(LOG)
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
